//--- Bender.yml
package:
  name: delay_bank

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - hw/delay_bank_pkg.sv
      - hw/slot_ram.sv
      - hw/slot_allocator.sv
      - hw/list_ctrl.sv
      - hw/release_arbiter.sv
      - hw/delay_bank.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_delay_bank.sv

//--- all.f
hw/delay_bank_pkg.sv
hw/slot_ram.sv
hw/slot_allocator.sv
hw/list_ctrl.sv
hw/release_arbiter.sv
hw/delay_bank.sv
sim/tb_delay_bank.sv

//--- hw/delay_bank.sv
// ********************
// Delay bank
// Per-ID FIFO ordering over a shared linked-list store
// ********************

`timescale 1ns/100ps
`default_nettype none

module delay_bank (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  delay_bank_pkg::msg_t     msg_i,
  input  logic                     in_valid_i,
  input  logic                     out_ready_i,
  output logic                     out_valid_o,
  output delay_bank_pkg::payload_t data_o
);

  import delay_bank_pkg::*;

  logic                  alloc;
  logic                  free_en;
  slot_t                 free_slot;
  slot_t                 alloc_slot;
  pay_wr_t               pay_wr;
  ptr_wr_t               ptr_wr;
  ram_rd_t               pay_rd;
  ram_rd_t               ptr_rd;
  payload_t              pay_rdata;
  slot_t                 ptr_rdata;
  id_mask_t              buf_valid;
  payload_t [NumIds-1:0] buf_data;
  id_mask_t              release_onehot;

  list_ctrl i_list_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .msg_i           (msg_i),
    .in_valid_i      (in_valid_i),
    .out_ready_i     (out_ready_i),
    .release_onehot_i(release_onehot),
    .free_slot_i     (alloc_slot),
    .alloc_o         (alloc),
    .free_en_o       (free_en),
    .free_slot_o     (free_slot),
    .pay_wr_o        (pay_wr),
    .pay_rd_o        (pay_rd),
    .ptr_wr_o        (ptr_wr),
    .ptr_rd_o        (ptr_rd),
    .pay_rdata_i     (pay_rdata),
    .ptr_rdata_i     (ptr_rdata),
    .buf_valid_o     (buf_valid),
    .buf_data_o      (buf_data)
  );

  release_arbiter i_release_arbiter (
    .buf_valid_i     (buf_valid),
    .buf_data_i      (buf_data),
    .msg_i           (msg_i),
    .in_valid_i      (in_valid_i),
    .release_onehot_o(release_onehot),
    .out_valid_o     (out_valid_o),
    .data_o          (data_o)
  );

  slot_allocator i_slot_allocator (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .alloc_i    (alloc),
    .free_en_i  (free_en),
    .free_slot_i(free_slot),
    .free_slot_o(alloc_slot)
  );

  // Payload store
  slot_ram #(.Width(PayloadWidth)) i_pay_ram (
    .clk_i  (clk_i),
    .wr_i   (pay_wr),
    .rd_i   (pay_rd),
    .rdata_o(pay_rdata)
  );

  // Next-pointer store
  slot_ram #(.Width(SlotWidth)) i_ptr_ram (
    .clk_i  (clk_i),
    .wr_i   (ptr_wr),
    .rd_i   (ptr_rd),
    .rdata_o(ptr_rdata)
  );

endmodule

`default_nettype wire

//--- hw/delay_bank_pkg.sv
// ********************
// Delay bank package
// Sizes, vector types and structs shared by the bank
// ********************

`default_nettype none

package delay_bank_pkg;

  // Bank sizes
  localparam int NumIds       = 4;
  localparam int IdWidth      = 2;
  localparam int NumSlots     = 16;
  localparam int SlotWidth    = 4;
  localparam int PayloadWidth = 16;

  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [SlotWidth-1:0]    slot_t;
  typedef logic [PayloadWidth-1:0] payload_t;
  typedef logic [NumIds-1:0]       id_mask_t;

  // Incoming message
  typedef struct packed {
    id_t      id;
    payload_t payload;
  } msg_t;

  // Write port of the payload store
  typedef struct packed {
    logic     en;
    slot_t    addr;
    payload_t data;
  } pay_wr_t;

  // Write port of the next-pointer store
  typedef struct packed {
    logic  en;
    slot_t addr;
    slot_t data;
  } ptr_wr_t;

  // Read request, data returns one cycle later
  typedef struct packed {
    logic  en;
    slot_t addr;
  } ram_rd_t;

endpackage

`default_nettype wire

//--- hw/list_ctrl.sv
// ********************
// List controller
// Per-ID linked lists, output buffers and storage port requests
// ********************

`timescale 1ns/100ps
`default_nettype none

module list_ctrl (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  delay_bank_pkg::msg_t                              msg_i,
  input  logic                                              in_valid_i,
  input  logic                                              out_ready_i,
  input  delay_bank_pkg::id_mask_t                          release_onehot_i,
  input  delay_bank_pkg::slot_t                             free_slot_i,
  output logic                                              alloc_o,
  output logic                                              free_en_o,
  output delay_bank_pkg::slot_t                             free_slot_o,
  output delay_bank_pkg::pay_wr_t                           pay_wr_o,
  output delay_bank_pkg::ram_rd_t                           pay_rd_o,
  output delay_bank_pkg::ptr_wr_t                           ptr_wr_o,
  output delay_bank_pkg::ram_rd_t                           ptr_rd_o,
  input  delay_bank_pkg::payload_t                          pay_rdata_i,
  input  delay_bank_pkg::slot_t                             ptr_rdata_i,
  output delay_bank_pkg::id_mask_t                          buf_valid_o,
  output delay_bank_pkg::payload_t [delay_bank_pkg::NumIds-1:0] buf_data_o
);

  import delay_bank_pkg::*;

  // Number of messages in storage, up to NumSlots
  typedef logic [SlotWidth:0] len_t;

  slot_t    [NumIds-1:0] head_d, head_q, head_act;
  slot_t    [NumIds-1:0] tail_d, tail_q;
  len_t     [NumIds-1:0] len_d, len_q;
  payload_t [NumIds-1:0] buf_d, buf_q, buf_act;
  id_mask_t              buf_valid_d, buf_valid_q;
  id_mask_t              head_from_ram_d, head_from_ram_q;
  id_mask_t              buf_from_ram_d, buf_from_ram_q;
  id_mask_t              pop, push;

  for (genvar i = 0; i < NumIds; i++) begin : g_id
    assign pop[i]  = out_ready_i && release_onehot_i[i];
    assign push[i] = in_valid_i && (msg_i.id == id_t'(i));

    // Read data is only valid in the cycle after the pop that requested it
    assign head_act[i] = head_from_ram_q[i] ? ptr_rdata_i : head_q[i];
    assign buf_act[i]  = buf_from_ram_q[i] ? pay_rdata_i : buf_q[i];
  end

  assign buf_valid_o = buf_valid_q;
  assign buf_data_o  = buf_act;

  // At most one ID pops and one ID pushes, so port requests merge without conflict
  always_comb begin
    pay_wr_o    = '0;
    pay_rd_o    = '0;
    ptr_wr_o    = '0;
    ptr_rd_o    = '0;
    alloc_o     = 1'b0;
    free_en_o   = 1'b0;
    free_slot_o = '0;
    for (int i = 0; i < NumIds; i++) begin
      head_d[i]          = head_act[i];
      tail_d[i]          = tail_q[i];
      len_d[i]           = len_q[i];
      buf_d[i]           = buf_act[i];
      buf_valid_d[i]     = buf_valid_q[i];
      head_from_ram_d[i] = 1'b0;
      buf_from_ram_d[i]  = 1'b0;

      // Output side first; an empty buffer means flow-through
      if (pop[i] && buf_valid_q[i]) begin
        if (len_q[i] != '0) begin
          // Refill the buffer from the list head
          pay_rd_o          = '{en: 1'b1, addr: head_act[i]};
          free_en_o         = 1'b1;
          free_slot_o       = head_act[i];
          buf_from_ram_d[i] = 1'b1;
          len_d[i]          = len_q[i] - 1'b1;
          if (len_q[i] > len_t'(1)) begin
            ptr_rd_o           = '{en: 1'b1, addr: head_act[i]};
            head_from_ram_d[i] = 1'b1;
          end
        end else if (push[i]) begin
          buf_d[i] = msg_i.payload;
        end else begin
          buf_valid_d[i] = 1'b0;
        end
      end

      if (push[i]) begin
        if (!buf_valid_q[i]) begin
          if (!pop[i]) begin
            buf_valid_d[i] = 1'b1;
            buf_d[i]       = msg_i.payload;
          end
        end else if (!(pop[i] && len_q[i] == '0)) begin
          // Append to the list in storage
          alloc_o  = 1'b1;
          pay_wr_o = '{en: 1'b1, addr: free_slot_i, data: msg_i.payload};
          if (len_d[i] != '0) begin
            ptr_wr_o = '{en: 1'b1, addr: tail_q[i], data: free_slot_i};
          end else begin
            head_d[i] = free_slot_i;
          end
          tail_d[i] = free_slot_i;
          len_d[i]  = len_d[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q          <= '0;
      tail_q          <= '0;
      len_q           <= '0;
      buf_valid_q     <= '0;
      head_from_ram_q <= '0;
      buf_from_ram_q  <= '0;
    end else begin
      head_q          <= head_d;
      tail_q          <= tail_d;
      len_q           <= len_d;
      buf_valid_q     <= buf_valid_d;
      head_from_ram_q <= head_from_ram_d;
      buf_from_ram_q  <= buf_from_ram_d;
    end
  end

  // Buffered payloads
  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
  end

  for (genvar i = 0; i < NumIds; i++) begin : g_len_chk
    // A list with entries always has a valid buffer in front of it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     (len_q[i] <= len_t'(NumSlots)) && (len_q[i] == '0 || buf_valid_q[i]))
      else $error("list_ctrl: list %0d length %0d out of range", i, len_q[i]);
  end

endmodule

`default_nettype wire

//--- hw/release_arbiter.sv
// ********************
// Release arbiter
// Picks the lowest ID with a message and muxes its data
// ********************

`timescale 1ns/100ps
`default_nettype none

module release_arbiter (
  input  delay_bank_pkg::id_mask_t                              buf_valid_i,
  input  delay_bank_pkg::payload_t [delay_bank_pkg::NumIds-1:0] buf_data_i,
  input  delay_bank_pkg::msg_t                                  msg_i,
  input  logic                                                  in_valid_i,
  output delay_bank_pkg::id_mask_t                              release_onehot_o,
  output logic                                                  out_valid_o,
  output delay_bank_pkg::payload_t                              data_o
);

  import delay_bank_pkg::*;

  id_mask_t cand;

  // A buffered message or an incoming one makes an ID eligible
  for (genvar i = 0; i < NumIds; i++) begin : g_cand
    assign cand[i] = buf_valid_i[i] || (in_valid_i && (msg_i.id == id_t'(i)));
  end

  // Fixed priority, lowest ID wins
  always_comb begin
    release_onehot_o = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (cand[i]) begin
        release_onehot_o    = '0;
        release_onehot_o[i] = 1'b1;
      end
    end
  end

  assign out_valid_o = |cand;

  // Winner without a buffered message is the incoming ID, so flow through
  always_comb begin
    data_o = msg_i.payload;
    for (int i = 0; i < NumIds; i++) begin
      if (release_onehot_o[i] && buf_valid_i[i]) begin
        data_o = buf_data_i[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/slot_allocator.sv
// ********************
// Slot allocator
// Valid bit per slot and lowest free slot search
// ********************

`timescale 1ns/100ps
`default_nettype none

module slot_allocator (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  alloc_i,
  input  logic                  free_en_i,
  input  delay_bank_pkg::slot_t free_slot_i,
  output delay_bank_pkg::slot_t free_slot_o
);

  import delay_bank_pkg::*;

  logic [NumSlots-1:0] valid_d;
  logic [NumSlots-1:0] valid_q;

  // Lowest clear bit wins, scan from the top down
  always_comb begin
    free_slot_o = '0;
    for (int s = NumSlots - 1; s >= 0; s--) begin
      if (!valid_q[s]) begin
        free_slot_o = slot_t'(s);
      end
    end
  end

  // Allocated and freed slots always differ, so both updates can apply
  always_comb begin
    valid_d = valid_q;
    if (alloc_i) begin
      valid_d[free_slot_o] = 1'b1;
    end
    if (free_en_i) begin
      valid_d[free_slot_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // Overflow of the shared storage
  assert property (@(posedge clk_i) disable iff (!rst_ni) alloc_i |-> !(&valid_q))
    else $error("slot_allocator: allocation with all slots taken");

  // A popped head must still be marked as taken
  assert property (@(posedge clk_i) disable iff (!rst_ni) free_en_i |-> valid_q[free_slot_i])
    else $error("slot_allocator: slot %0d freed twice", free_slot_i);

endmodule

`default_nettype wire

//--- hw/slot_ram.sv
// ********************
// Slot RAM
// NumSlots words, one write and one registered read port
// ********************

`timescale 1ns/100ps
`default_nettype none

module slot_ram #(
  parameter int Width = 16
) (
  input  logic                                      clk_i,
  input  logic [Width+delay_bank_pkg::SlotWidth:0]  wr_i,
  input  delay_bank_pkg::ram_rd_t                   rd_i,
  output logic [Width-1:0]                          rdata_o
);

  import delay_bank_pkg::*;

  // Same layout as the write structs of the package
  typedef struct packed {
    logic             en;
    slot_t            addr;
    logic [Width-1:0] data;
  } wr_t;

  wr_t              wr;
  logic [Width-1:0] mem_q [NumSlots];

  assign wr = wr_t'(wr_i);

  always_ff @(posedge clk_i) begin
    if (wr.en) begin
      mem_q[wr.addr] <= wr.data;
    end
    if (rd_i.en) begin
      rdata_o <= mem_q[rd_i.addr];
    end
  end

  // A slot is never written while the bank reads it back
  assert property (@(posedge clk_i) (wr.en && rd_i.en) |-> (wr.addr != rd_i.addr))
    else $error("slot_ram: read and write hit slot %0d", wr.addr);

endmodule

`default_nettype wire

//--- sim/tb_delay_bank.sv
// ********************
// Delay bank testbench
// Directed and random traffic checked against per-ID queues
// ********************

`timescale 1ns/100ps
`default_nettype none

module tb_delay_bank;

  import delay_bank_pkg::*;

  localparam int RandomCycles  = 3000;
  // Reset and directed phases need well under 1000 cycles
  localparam int TimeoutCycles = RandomCycles + 1000;

  logic     clk;
  logic     rst_n;
  msg_t     msg;
  logic     in_valid;
  logic     out_ready;
  logic     out_valid;
  payload_t data;

  int seed      = 89075;
  int cycle_cnt = 0;
  int error_cnt = 0;

  // Reference model, one ring buffer per ID
  payload_t model_mem [NumIds][NumSlots];
  int       model_rd  [NumIds];
  int       model_cnt [NumIds];

  delay_bank i_delay_bank (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .msg_i      (msg),
    .in_valid_i (in_valid),
    .out_ready_i(out_ready),
    .out_valid_o(out_valid),
    .data_o     (data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped by the cycle limit");
  end

  function automatic int model_total();
    int sum;
    sum = 0;
    for (int i = 0; i < NumIds; i++) begin
      sum += model_cnt[i];
    end
    return sum;
  endfunction

  // Lowest ID holding a message, -1 when all queues are empty
  function automatic int lowest_busy_id();
    int found;
    found = -1;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (model_cnt[i] != 0) begin
        found = i;
      end
    end
    return found;
  endfunction

  task automatic model_push(input id_t id, input payload_t pay);
    int wr;
    wr = (model_rd[id] + model_cnt[id]) % NumSlots;
    model_mem[id][wr] = pay;
    model_cnt[id]++;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_cnt++;
      $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Drive one cycle, then compare outputs against the model before the next edge
  task automatic run_cycle(input logic valid, input id_t id, input payload_t pay,
                           input logic ready);
    int winner;
    @(posedge clk);
    #1;
    in_valid  = valid;
    msg       = '{id: id, payload: pay};
    out_ready = ready;
    #2;
    if (valid) begin
      model_push(id, pay);
    end
    winner = lowest_busy_id();
    check_value("out_valid_o", (winner >= 0) ? 32'd1 : 32'd0, {31'd0, out_valid});
    if (winner >= 0) begin
      check_value("data_o", {16'd0, model_mem[winner][model_rd[winner]]}, {16'd0, data});
      if (ready) begin
        model_rd[winner] = (model_rd[winner] + 1) % NumSlots;
        model_cnt[winner]--;
      end
    end
  endtask

  // Empty the bank, then confirm out_valid_o drops
  task automatic drain();
    while (model_total() != 0) begin
      run_cycle(1'b0, '0, '0, 1'b1);
    end
    run_cycle(1'b0, '0, '0, 1'b1);
  endtask

  initial begin
    logic     rnd_valid;
    logic     rnd_ready;
    id_t      rnd_id;
    payload_t rnd_pay;

    in_valid  = 1'b0;
    out_ready = 1'b0;
    msg       = '0;
    rst_n     = 1'b0;
    for (int i = 0; i < NumIds; i++) begin
      model_rd[i]  = 0;
      model_cnt[i] = 0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle after reset, then a single flow-through message
    run_cycle(1'b0, '0, '0, 1'b0);
    run_cycle(1'b1, 2'd1, 16'hA5A5, 1'b1);
    run_cycle(1'b0, '0, '0, 1'b1);

    // One ID stalled, so most messages pass through storage
    for (int k = 0; k < 8; k++) begin
      run_cycle(1'b1, 2'd2, payload_t'(16'h2000 + k), 1'b0);
    end
    drain();

    // Loaded highest ID first, released lowest ID first
    for (int k = 0; k < 12; k++) begin
      run_cycle(1'b1, id_t'(3 - (k % 4)), payload_t'(16'h3000 + k), 1'b0);
    end
    drain();

    // Back-to-back pops of one ID with pushes in the same cycles
    for (int k = 0; k < 4; k++) begin
      run_cycle(1'b1, 2'd0, payload_t'(16'h4000 + k), 1'b0);
    end
    for (int k = 0; k < 10; k++) begin
      run_cycle(1'b1, 2'd0, payload_t'(16'h4100 + k), 1'b1);
    end
    drain();

    // Random traffic, input held off while the bank is full
    for (int c = 0; c < RandomCycles; c++) begin
      rnd_valid = (model_total() < NumSlots) && (($random(seed) & 3) != 0);
      rnd_id    = id_t'($random(seed));
      rnd_pay   = payload_t'($random(seed));
      rnd_ready = ($random(seed) & 1) != 0;
      run_cycle(rnd_valid, rnd_id, rnd_pay, rnd_ready);
    end
    drain();

    if (error_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
